//--- design/fifo_defines.svh
// Async FIFO sizing macros shared by the packages and the controllers
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// ----------------------------------------------------------
// Pointer and storage geometry
// ----------------------------------------------------------

// Address bits, depth is 2**FIFO_PTR_WIDTH
`define FIFO_PTR_WIDTH 4

// Derived entry count
`define FIFO_DEPTH (1 << `FIFO_PTR_WIDTH)

// Width of one stored word
`define FIFO_DATA_WIDTH 16

// Flops in each Gray pointer synchronizer
`define FIFO_SYNC_STAGES 2

`endif

//--- design/fifo_ptr_pkg.sv
// Pointer, address and depth types of the async FIFO with Gray code conversion
`include "fifo_defines.svh"

package fifo_ptr_pkg;

	// ----------------------------------------------------------
	// Types
	// ----------------------------------------------------------

	typedef logic [`FIFO_PTR_WIDTH-1:0] addr_t;  // RAM address
	typedef logic [`FIFO_PTR_WIDTH:0]   ptr_t;   // Address plus wrap bit
	typedef logic [`FIFO_PTR_WIDTH:0]   depth_t; // 0 .. FIFO_DEPTH

	// ----------------------------------------------------------
	// Conversions
	// ----------------------------------------------------------

	// Binary to reflected Gray
	function automatic ptr_t bin2gray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

	// Gray back to binary, MSB first
	function automatic ptr_t gray2bin(input ptr_t gray);
		ptr_t bin;
		bin[`FIFO_PTR_WIDTH] = gray[`FIFO_PTR_WIDTH]; // Top bit unchanged
		for (int i = `FIFO_PTR_WIDTH - 1; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i]; // Running XOR
		end
		return bin;
	endfunction

endpackage

//--- design/fifo_data_pkg.sv
// Datapath word type of the async FIFO
`include "fifo_defines.svh"

package fifo_data_pkg;

	// One FIFO entry
	typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

endpackage

//--- design/gen_fifo_async_wrctl.sv
// Write-side FIFO controller with write pointer, read pointer sync, full flag and depth
`timescale 1ns/10ps
`include "fifo_defines.svh"

module gen_fifo_async_wrctl (
	input  logic                 wclk,                 // Write clock
	input  logic                 reset,                // Common reset
	input  logic                 push,                 // Write request
	input  fifo_ptr_pkg::ptr_t   far_read_addr_gray,   // Read pointer from rclk domain
	output fifo_ptr_pkg::ptr_t   faw_write_addr_gray,  // Registered Gray write pointer
	output fifo_ptr_pkg::addr_t  faw_ram_write_addr,
	output logic                 faw_ram_write_strobe,
	output logic                 faw_full,
	output fifo_ptr_pkg::depth_t faw_depth             // Depth seen from write side
);

	logic               wreset;                          // Reset in wclk
	fifo_ptr_pkg::ptr_t wbin;                            // Binary write pointer
	fifo_ptr_pkg::ptr_t wbin_next;
	fifo_ptr_pkg::ptr_t wgray_next;
	fifo_ptr_pkg::ptr_t rgray_sync [`FIFO_SYNC_STAGES];  // Read pointer synchronizer
	fifo_ptr_pkg::ptr_t rgray_w;                         // Read pointer in wclk
	fifo_ptr_pkg::ptr_t full_match;

	// Bring reset into this domain
	always_ff @(posedge wclk) begin
		wreset <= reset;
	end

	// ----------------------------------------------------------
	// Next pointer and full compare
	// ----------------------------------------------------------

	assign faw_ram_write_strobe = push & ~faw_full;   // Pushes while full are dropped
	assign wbin_next  = wbin + fifo_ptr_pkg::ptr_t'(faw_ram_write_strobe);
	assign wgray_next = fifo_ptr_pkg::bin2gray(wbin_next);
	assign faw_ram_write_addr = wbin[`FIFO_PTR_WIDTH-1:0];
	assign rgray_w = rgray_sync[`FIFO_SYNC_STAGES-1];

	// Full when one lap ahead of reader
	assign full_match = {~rgray_w[`FIFO_PTR_WIDTH -: 2], rgray_w[`FIFO_PTR_WIDTH-2:0]};

	always_ff @(posedge wclk) begin
		if (wreset) begin
			wbin                <= '0;
			faw_write_addr_gray <= '0;
			faw_full            <= 1'b0;
			faw_depth           <= '0;
		end else begin
			wbin                <= wbin_next;
			faw_write_addr_gray <= wgray_next;
			faw_full            <= (wgray_next == full_match);
			faw_depth           <= wbin_next - fifo_ptr_pkg::gray2bin(rgray_w); // Mod 2**(W+1)
		end
	end

	// ----------------------------------------------------------
	// Read pointer synchronizer
	// ----------------------------------------------------------

	always_ff @(posedge wclk) begin
		if (wreset) begin
			for (int i = 0; i < `FIFO_SYNC_STAGES; i++) begin
				rgray_sync[i] <= '0;
			end
		end else begin
			rgray_sync[0] <= far_read_addr_gray;  // First stage samples async
			for (int i = 1; i < `FIFO_SYNC_STAGES; i++) begin
				rgray_sync[i] <= rgray_sync[i-1];
			end
		end
	end

	// Gray full compare agrees with binary depth
	a_full_matches_depth: assert property (@(posedge wclk) disable iff (wreset)
		faw_full |-> (faw_depth == `FIFO_DEPTH));

	// Occupancy bounded by store size
	a_depth_bound: assert property (@(posedge wclk) disable iff (wreset)
		faw_depth <= `FIFO_DEPTH);

endmodule

//--- design/gen_fifo_async_rdctl.sv
// Read-side FIFO controller with read pointer, write pointer sync, empty flag, depth and dout_v
`timescale 1ns/10ps
`include "fifo_defines.svh"

module gen_fifo_async_rdctl (
	input  logic                 rclk,                 // Read clock
	input  logic                 reset,                // Common reset
	input  logic                 pop,                  // Read request
	input  fifo_ptr_pkg::ptr_t   faw_write_addr_gray,  // Write pointer from wclk domain
	output fifo_ptr_pkg::ptr_t   far_read_addr_gray,   // Registered Gray read pointer
	output fifo_ptr_pkg::addr_t  far_ram_read_addr,
	output logic                 far_ram_read_strobe,
	output logic                 far_empty,
	output logic                 far_dout_v,           // Store output valid
	output fifo_ptr_pkg::depth_t far_depth             // Depth seen from read side
);

	logic               rreset;                          // Reset in rclk
	fifo_ptr_pkg::ptr_t rbin;                            // Binary read pointer
	fifo_ptr_pkg::ptr_t rbin_next;
	fifo_ptr_pkg::ptr_t rgray_next;
	fifo_ptr_pkg::ptr_t wgray_sync [`FIFO_SYNC_STAGES];  // Write pointer synchronizer
	fifo_ptr_pkg::ptr_t wgray_r;                         // Write pointer in rclk

	// Bring reset into this domain
	always_ff @(posedge rclk) begin
		rreset <= reset;
	end

	// ----------------------------------------------------------
	// Next pointer and empty compare
	// ----------------------------------------------------------

	assign far_ram_read_strobe = pop & ~far_empty;    // Pops while empty do nothing
	assign rbin_next  = rbin + fifo_ptr_pkg::ptr_t'(far_ram_read_strobe);
	assign rgray_next = fifo_ptr_pkg::bin2gray(rbin_next);
	assign far_ram_read_addr = rbin[`FIFO_PTR_WIDTH-1:0];
	assign wgray_r = wgray_sync[`FIFO_SYNC_STAGES-1];

	always_ff @(posedge rclk) begin
		if (rreset) begin
			rbin               <= '0;
			far_read_addr_gray <= '0;
			far_empty          <= 1'b1;  // Nothing stored yet
			far_dout_v         <= 1'b0;
			far_depth          <= '0;
		end else begin
			rbin               <= rbin_next;
			far_read_addr_gray <= rgray_next;
			far_empty          <= (rgray_next == wgray_r);  // Caught up with writer
			far_dout_v         <= far_ram_read_strobe;      // Store read takes one cycle
			far_depth          <= fifo_ptr_pkg::gray2bin(wgray_r) - rbin_next;
		end
	end

	// ----------------------------------------------------------
	// Write pointer synchronizer
	// ----------------------------------------------------------

	always_ff @(posedge rclk) begin
		if (rreset) begin
			for (int i = 0; i < `FIFO_SYNC_STAGES; i++) begin
				wgray_sync[i] <= '0;
			end
		end else begin
			wgray_sync[0] <= faw_write_addr_gray;  // First stage samples async
			for (int i = 1; i < `FIFO_SYNC_STAGES; i++) begin
				wgray_sync[i] <= wgray_sync[i-1];
			end
		end
	end

	// Gray empty compare agrees with binary depth
	a_empty_matches_depth: assert property (@(posedge rclk) disable iff (rreset)
		far_empty |-> (far_depth == '0));

endmodule

//--- design/gen_fifo_async_ctl.sv
// Async FIFO controller wrapper joining write and read sides, with depth high-water marks
`timescale 1ns/10ps
`include "fifo_defines.svh"

module gen_fifo_async_ctl (
	input  logic                 wclk,
	input  logic                 rclk,
	input  logic                 reset,
	input  logic                 push,              // Write into FIFO
	input  logic                 pop,               // Read out of FIFO
	output logic                 full,              // wclk side
	output logic                 empty,             // rclk side
	output logic                 dout_v,
	output fifo_ptr_pkg::depth_t wdepth,
	output fifo_ptr_pkg::depth_t rdepth,
	output logic                 ram_write_strobe,
	output fifo_ptr_pkg::addr_t  ram_write_addr,
	output logic                 ram_read_strobe,
	output fifo_ptr_pkg::addr_t  ram_read_addr
);

	fifo_ptr_pkg::ptr_t   faw_write_addr_gray;  // Crosses to rclk
	fifo_ptr_pkg::ptr_t   far_read_addr_gray;   // Crosses to wclk
	fifo_ptr_pkg::depth_t max_wdepth;           // Debug high-water marks
	fifo_ptr_pkg::depth_t max_rdepth;

	gen_fifo_async_wrctl faw (
		.wclk                 (wclk),
		.reset                (reset),
		.push                 (push),
		.far_read_addr_gray   (far_read_addr_gray),
		.faw_write_addr_gray  (faw_write_addr_gray),
		.faw_ram_write_addr   (ram_write_addr),
		.faw_ram_write_strobe (ram_write_strobe),
		.faw_full             (full),
		.faw_depth            (wdepth)
	);

	gen_fifo_async_rdctl far (
		.rclk                (rclk),
		.reset               (reset),
		.pop                 (pop),
		.faw_write_addr_gray (faw_write_addr_gray),
		.far_read_addr_gray  (far_read_addr_gray),
		.far_ram_read_addr   (ram_read_addr),
		.far_ram_read_strobe (ram_read_strobe),
		.far_empty           (empty),
		.far_dout_v          (dout_v),
		.far_depth           (rdepth)
	);

	// ----------------------------------------------------------
	// High-water marks, one per domain
	// ----------------------------------------------------------

	always_ff @(posedge wclk) begin
		if (reset)
			max_wdepth <= '0;
		else if (wdepth > max_wdepth)
			max_wdepth <= wdepth;
	end

	always_ff @(posedge rclk) begin
		if (reset)
			max_rdepth <= '0;
		else if (rdepth > max_rdepth)
			max_rdepth <= rdepth;
	end

	// Reader never sees more than writer ever held
	a_rdepth_le_wmark: assert property (@(posedge rclk) disable iff (reset)
		rdepth <= max_wdepth);

	a_rmark_bound: assert property (@(posedge rclk) disable iff (reset)
		max_rdepth <= `FIFO_DEPTH);

endmodule

//--- design/fifo_dp_ram.sv
// Dual-clock register-file store for the async FIFO with registered read port
`timescale 1ns/10ps
`include "fifo_defines.svh"

module fifo_dp_ram (
	input  logic                wclk,          // Write port clock
	input  logic                rclk,          // Read port clock
	input  logic                write_strobe,
	input  fifo_ptr_pkg::addr_t write_addr,
	input  fifo_data_pkg::data_t din,
	input  logic                read_strobe,
	input  fifo_ptr_pkg::addr_t read_addr,
	output fifo_data_pkg::data_t dout         // Holds between reads
);

	fifo_data_pkg::data_t mem [`FIFO_DEPTH];   // Storage array

	// ----------------------------------------------------------
	// Write port
	// ----------------------------------------------------------

	always_ff @(posedge wclk) begin
		if (write_strobe)
			mem[write_addr] <= din;
	end

	// ----------------------------------------------------------
	// Read port
	// ----------------------------------------------------------

	// Entry read is always one already synced across
	always_ff @(posedge rclk) begin
		if (read_strobe)
			dout <= mem[read_addr];
	end

endmodule

//--- design/async_fifo_top.sv
// Async FIFO top level joining the pointer controller and the data store
`timescale 1ns/10ps

module async_fifo_top (
	// Write side
	input  logic                 wclk,
	input  logic                 push,
	input  fifo_data_pkg::data_t din,
	output logic                 full,
	output fifo_ptr_pkg::depth_t wdepth,
	// Read side
	input  logic                 rclk,
	input  logic                 pop,
	output fifo_data_pkg::data_t dout,
	output logic                 dout_v,     // One cycle per accepted pop
	output logic                 empty,
	output fifo_ptr_pkg::depth_t rdepth,
	// Common
	input  logic                 reset
);

	logic                ram_write_strobe;
	fifo_ptr_pkg::addr_t ram_write_addr;
	logic                ram_read_strobe;
	fifo_ptr_pkg::addr_t ram_read_addr;

	// Pointers and flags
	gen_fifo_async_ctl ctl (
		.wclk             (wclk),
		.rclk             (rclk),
		.reset            (reset),
		.push             (push),
		.pop              (pop),
		.full             (full),
		.empty            (empty),
		.dout_v           (dout_v),
		.wdepth           (wdepth),
		.rdepth           (rdepth),
		.ram_write_strobe (ram_write_strobe),
		.ram_write_addr   (ram_write_addr),
		.ram_read_strobe  (ram_read_strobe),
		.ram_read_addr    (ram_read_addr)
	);

	// Data store
	fifo_dp_ram ram (
		.wclk         (wclk),
		.rclk         (rclk),
		.write_strobe (ram_write_strobe),
		.write_addr   (ram_write_addr),
		.din          (din),
		.read_strobe  (ram_read_strobe),
		.read_addr    (ram_read_addr),
		.dout         (dout)
	);

endmodule

//--- bench/async_fifo_tb.sv
// Testbench for the async FIFO with a table of push/pop rows checked against a scoreboard queue
`timescale 1ns/10ps

module async_fifo_tb;

	typedef struct packed {
		int pushes;    // Attempts or accepted words when concurrent
		int pops;
		bit conc;      // Push and pop sides run together with random gaps
		bit exp_full;
		bit exp_empty;
		int exp_depth;
		int exp_reads; // Words expected on dout during the row
	} row_t;

	logic wclk = 1'b0;
	logic rclk = 1'b0;
	logic reset, push, pop;        // DUT controls
	logic full, empty, dout_v;     // DUT flags
	fifo_data_pkg::data_t din, dout;
	fifo_ptr_pkg::depth_t wdepth, rdepth;
	fifo_data_pkg::data_t sb [$];   // Scoreboard model of the FIFO
	row_t rows [7];
	int   errors = 0;
	int   checks = 0;
	int   reads = 0;

	async_fifo_top async_fifo_top_i (.wclk(wclk), .push(push), .din(din), .full(full),
		.wdepth(wdepth), .rclk(rclk), .pop(pop), .dout(dout), .dout_v(dout_v),
		.empty(empty), .rdepth(rdepth), .reset(reset));

	always #4 wclk = ~wclk;         // 8 ns write clock
	always begin                    // 8 ns read clock 3 ns behind
		#3;
		forever #4 rclk = ~rclk;
	end

	// ----------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------

	task automatic check_data(input string name, input fifo_data_pkg::data_t got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_depth(input string name, input fifo_ptr_pkg::depth_t got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	// ----------------------------------------------------------
	// Drivers with a try limit on every loop
	// ----------------------------------------------------------

	task automatic drive_pushes(input int n, input bit retry);
		int done = 0;
		int tries = 0;
		while (done < n && tries < 400) begin
			@(posedge wclk);
			#1;
			tries++;
			push = !(retry && $urandom_range(3, 0) == 0);  // Gap one cycle in four
			din  = fifo_data_pkg::data_t'($urandom);
			if (push && !full)
				sb.push_back(din);                         // Taken on the next edge
			if (push && (!full || !retry))
				done++;
		end
		@(posedge wclk);
		#1 push = 1'b0;
		if (done < n) begin
			errors++;
			$display("Push side gave up after %0d tries with %0d of %0d done", tries, done, n);
		end
	endtask

	task automatic drive_pops(input int n, input bit retry);
		int done = 0;
		int tries = 0;
		while (done < n && tries < 400) begin
			@(posedge rclk);
			#1;
			tries++;
			pop = !(retry && $urandom_range(3, 0) == 0);
			if (pop && (!empty || !retry))
				done++;
		end
		@(posedge rclk);
		#1 pop = 1'b0;
		if (done < n) begin
			errors++;
			$display("Pop side gave up after %0d tries with %0d of %0d done", tries, done, n);
		end
	endtask

	// Wait up to 20 cycles for flags, both depths and the scoreboard to agree
	task automatic wait_settled(input bit ef, ee, input fifo_ptr_pkg::depth_t ed, output bit ok);
		ok = 1'b0;
		for (int i = 0; i < 20 && !ok; i++) begin
			@(negedge wclk);
			ok = full === ef && empty === ee && wdepth === ed && rdepth === ed
				&& sb.size() == int'(ed);
		end
	endtask

	// Read data monitor at mid-cycle where dout is stable
	always @(negedge rclk) begin
		if (dout_v === 1'b1) begin
			reads++;
			if (sb.size() == 0) begin
				errors++;
				$display("dout_v came with no word left in the scoreboard");
			end else
				check_data("dout", dout, sb.pop_front());
		end
	end

	initial begin
		int  errs_before, reads_before;
		bit  ok;
		void'($urandom(32'h4a24));
		reset = 1'b1;
		push  = 1'b0;
		pop   = 1'b0;
		din   = '0;
		//        push pop conc full empty depth reads
		rows = '{'{0,  0,  0, 0, 1, 0,  0},   // After reset
			'{5,  0,  0, 0, 0, 5,  0},        // Write five
			'{0,  5,  0, 0, 1, 0,  5},        // Read them back
			'{20, 0,  0, 1, 0, 16, 0},        // Overfill drops four
			'{0,  16, 0, 0, 1, 0,  16},
			'{0,  4,  0, 0, 1, 0,  0},        // Pop while empty
			'{40, 40, 1, 0, 1, 0,  40}};      // Streaming
		repeat (3) @(posedge wclk);
		#1 reset = 1'b0;
		for (int r = 0; r < 7; r++) begin
			errs_before  = errors;
			reads_before = reads;
			if (rows[r].conc) begin
				fork
					drive_pushes(rows[r].pushes, 1'b1);
					drive_pops(rows[r].pops, 1'b1);
				join
			end else begin
				drive_pushes(rows[r].pushes, 1'b0);
				drive_pops(rows[r].pops, 1'b0);
			end
			wait_settled(rows[r].exp_full, rows[r].exp_empty,
				fifo_ptr_pkg::depth_t'(rows[r].exp_depth), ok);
			if (!ok) begin
				errors++;
				$display("Row %0d: flags and depths did not settle within 20 cycles", r);
			end
			check_flag("full", full, rows[r].exp_full);
			check_flag("empty", empty, rows[r].exp_empty);
			check_depth("wdepth", wdepth, fifo_ptr_pkg::depth_t'(rows[r].exp_depth));
			check_depth("rdepth", rdepth, fifo_ptr_pkg::depth_t'(rows[r].exp_depth));
			check_count("reads", reads - reads_before, rows[r].exp_reads);
			$display("Row %0d: %0d pushes %0d pops, %0d errors", r, rows[r].pushes,
				rows[r].pops, errors - errs_before);
		end
		$display("%0d rows, %0d checks, %0d errors", 7, checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+design
design/fifo_ptr_pkg.sv
design/fifo_data_pkg.sv
design/gen_fifo_async_wrctl.sv
design/gen_fifo_async_rdctl.sv
design/gen_fifo_async_ctl.sv
design/fifo_dp_ram.sv
design/async_fifo_top.sv
bench/async_fifo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the async FIFO testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module async_fifo_tb -Mdir obj_dir -o async_fifo_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/async_fifo_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
